// File: source/kd_cfg.svh
`ifndef KD_CFG_SVH
`define KD_CFG_SVH

// Number of internal levels in the tree, giving 2**KD_DEPTH leaves
`define KD_DEPTH 5

// Number of components in one query patch
`define KD_DIMS 5

// Bit width of one patch component and of a node median
`define KD_COMP_W 11
`define KD_DIM_W 3 // Wide enough to name any of the KD_DIMS components

`endif

// File: source/kd_pkg.sv
`include "kd_cfg.svh"

package kd_pkg;

  // One patch component, compared unsigned against a node median
  typedef logic [`KD_COMP_W-1:0] comp_t;

  // Full query patch, component 0 sits in the low bits
  typedef comp_t [`KD_DIMS-1:0] patch_t;

  // Contents of one internal node of the tree
  typedef struct packed {
    logic [`KD_DIM_W-1:0] split_dim; // Which patch component this node looks at
    comp_t                median;    // Split point, equal values go right
  } node_t;

  // Node write as broadcast from the loader to every level
  typedef struct packed {
    logic [`KD_DEPTH-1:0] slot; // Position of the node inside its level
    node_t                node;
  } node_wr_t;

  // Binary leaf number produced at the bottom of the tree
  // Bit k of the index is the branch taken at level KD_DEPTH-1-k
  typedef logic [`KD_DEPTH-1:0] leaf_idx_t;

  // Sanity numbers derived from the same defines
  localparam int PATCH_W = $bits(patch_t);   // 55 bits in the default build
  localparam int NODE_W  = $bits(node_t);    // 14 bits in the default build
  localparam int WR_W    = $bits(node_wr_t); // 19 bits in the default build
  localparam int LEAVES  = 2**`KD_DEPTH;     // Width of the last valid vector

endpackage

// File: source/kd_node_loader.sv
`timescale 1ns/1ps
`include "kd_cfg.svh"

module kd_node_loader
  import kd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load_en,    // Load window is open
  input  logic                 load_valid, // Sender has a node on load_node
  input  node_t                load_node,
  output node_wr_t             wr,         // Shared write bus to all levels
  output logic [`KD_DEPTH-1:0] level_sel,  // One-hot level strobe for this write
  output logic                 load_done   // Whole tree has been written
);

  // The level counter holds one extra code so it can step past the last level
  localparam int LVL_W  = $clog2(`KD_DEPTH + 1);
  localparam int SLOT_W = `KD_DEPTH;

  logic [LVL_W-1:0]  level;      // Level that the next write goes to
  logic [SLOT_W-1:0] slot;       // Slot inside that level
  logic [SLOT_W-1:0] slot_last;  // Highest slot of the current level
  logic              last_level; // Current level is the bottom one
  logic              accept;     // A write lands on this edge

  // Writes are refused once the tree is full, so late strobes do nothing
  assign accept = load_en && load_valid && !load_done;

  // Level k has 2**k slots, the last one is 2**k - 1
  assign slot_last  = SLOT_W'((1 << level) - 1);
  assign last_level = (level == LVL_W'(`KD_DEPTH - 1));

  // Breadth-first walk over the tree, one node per accepted write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      level     <= '0;
      slot      <= '0;
      load_done <= 1'b0;
    end else if (accept) begin
      if (slot == slot_last) begin
        slot  <= '0;            // Level is full, start the next one at slot 0
        level <= level + 1'b1;
        if (last_level) begin
          load_done <= 1'b1;    // Rises on the edge that takes the final node
        end
      end else begin
        slot <= slot + 1'b1;
      end
    end
  end

  // Decode the level, nothing is selected when no write is accepted
  always_comb begin
    level_sel = '0;
    if (accept) begin
      level_sel = SLOT_W'(1) << level;
    end
  end

  // Node data goes straight through, tagged with its slot
  assign wr.slot = slot;
  assign wr.node = load_node;

  // Only one level may capture a given write
  a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(level_sel));

endmodule

// File: source/kd_tree_level.sv
`timescale 1ns/1ps
`include "kd_cfg.svh"

module kd_tree_level
  import kd_pkg::*;
#(
  parameter int LEVEL = 0 // Depth of this level, the root is level 0
)(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_en,     // This level owns the current write
  input  node_wr_t                   wr,
  input  logic [(2**LEVEL)-1:0]      valid_in,  // One-hot position of the query here
  input  patch_t                     patch_in,
  output logic [(2**(LEVEL+1))-1:0]  valid_out, // Position one level further down
  output patch_t                     patch_out
);

  localparam int NODES  = 2**LEVEL;
  localparam int SLOT_W = `KD_DEPTH;

  node_t              nodes     [NODES]; // Node registers of this level
  comp_t              sel_comp  [NODES]; // Component each node looks at
  logic               go_right  [NODES]; // Branch decision per node
  logic [2*NODES-1:0] child_valid;       // Next-level vector before the register

  // Node storage, each slot matches its own address on the shared bus
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NODES; s++) begin
        nodes[s] <= '0;
      end
    end else if (wr_en) begin
      for (int s = 0; s < NODES; s++) begin
        if (wr.slot == SLOT_W'(s)) begin
          nodes[s] <= wr.node;
        end
      end
    end
  end

  // Every node compares in parallel, only the one holding the valid bit matters
  always_comb begin
    for (int s = 0; s < NODES; s++) begin
      sel_comp[s] = patch_in[nodes[s].split_dim];
      go_right[s] = (sel_comp[s] >= nodes[s].median); // Ties go right
      // Children of slot s sit at 2s (left) and 2s+1 (right) in the next level
      child_valid[2*s+1] = valid_in[s] && go_right[s];
      child_valid[2*s]   = valid_in[s] && !go_right[s];
    end
  end

  // Pipeline register toward the next level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= '0;
    end else begin
      valid_out <= child_valid;
    end
  end

  // The patch only travels along with its valid vector
  always_ff @(posedge clk) begin
    patch_out <= patch_in;
  end

  // A query occupies at most one node of a level
  a_valid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(valid_in));

  // A node in use must name a real component of the patch
  for (genvar s = 0; s < NODES; s++) begin : g_dim_chk
    a_dim_range: assert property (@(posedge clk) disable iff (!rst_n)
      valid_in[s] |-> (nodes[s].split_dim < `KD_DIMS));
  end

endmodule

// File: source/kd_leaf_encoder.sv
`timescale 1ns/1ps
`include "kd_cfg.svh"

module kd_leaf_encoder
  import kd_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [(2**`KD_DEPTH)-1:0] valid_in,   // One-hot leaf vector from the last level
  output logic                      leaf_valid, // Result strobe, one cycle per query
  output leaf_idx_t                 leaf_index  // Binary number of the reached leaf
);

  localparam int N_LEAF = 2**`KD_DEPTH;

  leaf_idx_t idx_d; // Encoded index before the output register
  logic      any_d; // Some leaf is reached this cycle

  // Priority encoder, the lowest set bit wins
  // With a one-hot input this is just the position of that bit
  always_comb begin
    idx_d = '0;
    for (int i = N_LEAF - 1; i >= 0; i--) begin
      if (valid_in[i]) begin
        idx_d = leaf_idx_t'(i);
      end
    end
  end

  assign any_d = |valid_in;

  // Result strobe, cleared by reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      leaf_valid <= 1'b0;
    end else begin
      leaf_valid <= any_d;
    end
  end

  // Index only means something while leaf_valid is high
  always_ff @(posedge clk) begin
    leaf_index <= idx_d;
  end

  // The tree delivers each query to a single leaf
  a_leaf_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(valid_in));

endmodule

// File: source/kd_search_top.sv
`timescale 1ns/1ps
`include "kd_cfg.svh"

module kd_search_top
  import kd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load_en,     // Load window
  input  logic      load_valid,  // Node write strobe
  input  node_t     load_node,   // Node payload, breadth-first order
  input  logic      query_valid, // Qualifies query_patch for one cycle
  input  patch_t    query_patch,
  output logic      load_done,   // All internal nodes written
  output logic      leaf_valid,  // Result strobe, KD_DEPTH+1 cycles after the query
  output leaf_idx_t leaf_index
);

  node_wr_t                  wr;          // Shared node write bus
  logic [`KD_DEPTH-1:0]      level_sel;   // Which level captures the write
  logic [(2**`KD_DEPTH)-1:0] final_valid; // Leaf vector out of the bottom level

  // Steers breadth-first writes to their level and slot
  kd_node_loader u_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_en    (load_en),
    .load_valid (load_valid),
    .load_node  (load_node),
    .wr         (wr),
    .level_sel  (level_sel),
    .load_done  (load_done)
  );

  // One pipeline stage per tree level, each doubles the valid vector
  for (genvar k = 0; k < `KD_DEPTH; k++) begin : g_lvl
    logic [(2**k)-1:0]     v_in;  // Query position entering this level
    logic [(2**(k+1))-1:0] v_out; // Query position leaving this level
    patch_t                p_in;
    patch_t                p_out;

    if (k == 0) begin : g_root
      assign v_in = query_valid; // The root is a single node
      assign p_in = query_patch;
    end else begin : g_inner
      assign v_in = g_lvl[k-1].v_out;
      assign p_in = g_lvl[k-1].p_out;
    end

    kd_tree_level #(
      .LEVEL (k)
    ) u_level (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en     (level_sel[k]),
      .wr        (wr),
      .valid_in  (v_in),
      .patch_in  (p_in),
      .valid_out (v_out),
      .patch_out (p_out)
    );
  end

  // The patch is no longer needed below the last level
  assign final_valid = g_lvl[`KD_DEPTH-1].v_out;

  kd_leaf_encoder u_encoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_in   (final_valid),
    .leaf_valid (leaf_valid),
    .leaf_index (leaf_index)
  );

endmodule

// File: sim/kd_search_tb.sv
`timescale 1ns/1ps
`include "kd_cfg.svh"

module kd_search_tb
  import kd_pkg::*;
();

  localparam int N_NODES = (2**`KD_DEPTH) - 1; // Internal nodes written breadth-first
  localparam int LATENCY = `KD_DEPTH + 1;      // Edges from query sample to leaf_valid

  logic      clk;
  logic      rst_n;
  logic      load_en;
  logic      load_valid;
  node_t     load_node;
  logic      query_valid;
  patch_t    query_patch;
  logic      load_done;
  logic      leaf_valid;
  leaf_idx_t leaf_index;

  leaf_idx_t exp_leaf;  // Expected leaf that travels alongside query_patch
  logic      file_read; // Vectors are in memory and the watchdog may start

  node_t     nodes_f [N_NODES]; // Tree as given by the vector file
  patch_t    q_patch [$];       // Query patches from the file
  leaf_idx_t q_leaf  [$];       // Their expected leaves
  leaf_idx_t exp_q   [$];       // Scoreboard of queries in flight
  int        due_q   [$];       // Negedge count at which each result must show
  int        neg_cnt;           // Negedges since reset was released
  int        accepted;          // Node writes the tree should have taken

  kd_search_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en     (load_en),
    .load_valid  (load_valid),
    .load_node   (load_node),
    .query_valid (query_valid),
    .query_patch (query_patch),
    .load_done   (load_done),
    .leaf_valid  (leaf_valid),
    .leaf_index  (leaf_index)
  );

  always #2 clk = ~clk; // 4 ns period

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_leaf(input string name, input leaf_idx_t got, input leaf_idx_t exp);
    if (got !== exp) begin
      $display("error: time %0t %s got %0d expected %0d", $time, name, got, exp);
      fail_run("leaf index mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: time %0t %s got %b expected %b", $time, name, got, exp);
      fail_run("control flag mismatch");
    end
  endtask

  // Walks the file's tree, right on at or above the median, path bits give the leaf
  function automatic leaf_idx_t walk_tree(input patch_t p);
    int    slot;
    node_t n;
    slot = 0;
    for (int lvl = 0; lvl < `KD_DEPTH; lvl++) begin
      n = nodes_f[(1 << lvl) - 1 + slot];
      slot = (p[n.split_dim] >= n.median) ? 2 * slot + 1 : 2 * slot;
    end
    return leaf_idx_t'(slot);
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    load_en     <= 1'b0;
    load_valid  <= 1'b0;
    query_valid <= 1'b0;
  endtask

  // A few stall cycles with one strobe only, then the real write
  task automatic write_node(input node_t n);
    int stall;
    int pick;
    stall = $urandom % 4;
    for (int i = 0; i < stall; i++) begin
      pick = $urandom % 3;
      @(posedge clk);
      load_en    <= (pick == 0);
      load_valid <= (pick == 1);
      load_node  <= n;
    end
    @(posedge clk);
    load_en    <= 1'b1;
    load_valid <= 1'b1;
    load_node  <= n;
  endtask

  task automatic issue_query(input patch_t p, input leaf_idx_t leaf);
    @(posedge clk);
    load_en     <= 1'b0;
    load_valid  <= 1'b0;
    query_valid <= 1'b1;
    query_patch <= p;
    exp_leaf    <= leaf;
  endtask

  // Waits for every query in flight, bounded by the pipeline depth
  task automatic wait_drain();
    int i;
    idle_cycle();
    for (i = 0; i < LATENCY + 4 && due_q.size() != 0; i++) begin
      @(posedge clk);
    end
    if (due_q.size() != 0) begin
      fail_run("results did not come out of the pipeline");
    end
  endtask

  task automatic read_vectors();
    int    fd;
    int    c [6];
    byte   tag;
    string line;
    int    n;
    patch_t p;
    n = 0;
    fd = $fopen("sim/kd_search_vectors.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open the vector file");
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%c", tag) != 1) continue;
      if (tag == "N" && $sscanf(line, "%c %d %d", tag, c[0], c[1]) == 3) begin
        nodes_f[n].split_dim = c[0][`KD_DIM_W-1:0];
        nodes_f[n].median    = comp_t'(c[1]);
        n++;
      end else if (tag == "Q" &&
                   $sscanf(line, "%c %d %d %d %d %d %d", tag, c[0], c[1], c[2], c[3], c[4],
                           c[5]) == 7) begin
        for (int k = 0; k < `KD_DIMS; k++) begin
          p[k] = comp_t'(c[k]);
        end
        q_patch.push_back(p);
        q_leaf.push_back(leaf_idx_t'(c[5]));
      end
    end
    $fclose(fd);
    if (n != N_NODES) begin
      fail_run("vector file does not hold a full tree");
    end
  endtask

  // Scoreboard, sampled at the falling edge where DUT outputs are settled
  always @(negedge clk) begin
    if (!rst_n) begin
      neg_cnt  = 0;
      accepted = 0;
      exp_q.delete();
      due_q.delete();
    end else begin
      neg_cnt = neg_cnt + 1;
      check_flag("load_done", load_done, accepted >= N_NODES);
      if (load_en && load_valid && accepted < N_NODES) begin
        accepted = accepted + 1; // Taken at the coming rising edge
      end
      if (due_q.size() != 0 && due_q[0] == neg_cnt) begin
        check_flag("leaf_valid", leaf_valid, 1'b1);
        check_leaf("leaf_index", leaf_index, exp_q[0]);
        void'(due_q.pop_front());
        void'(exp_q.pop_front());
      end else begin
        check_flag("leaf_valid", leaf_valid, 1'b0); // Nothing is due this cycle
      end
      if (query_valid) begin
        exp_q.push_back(exp_leaf);
        due_q.push_back(neg_cnt + LATENCY); // First stage clocks it at the next rising edge
      end
    end
  end

  // Budget covers reset, stalled loading and three passes over the queries
  initial begin : watchdog
    int wd_cycles;
    wait (file_read === 1'b1);
    wd_cycles = 8 + N_NODES * 4 + 2 * (3 * q_patch.size()) + 20;
    #(wd_cycles * 4);
    fail_run("watchdog expired before the test finished");
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    load_en     = 1'b0;
    load_valid  = 1'b0;
    load_node   = '0;
    query_valid = 1'b0;
    query_patch = '0;
    exp_leaf    = '0;
    file_read   = 1'b0;
    void'($urandom(32'h5779));
    read_vectors();
    file_read = 1'b1;
    // The file's expected leaves must agree with a walk of its own tree
    for (int i = 0; i < q_patch.size(); i++) begin
      check_leaf("file_leaf", q_leaf[i], walk_tree(q_patch[i]));
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int n = 0; n < N_NODES; n++) begin
      write_node(nodes_f[n]);
    end
    idle_cycle();
    idle_cycle();
    if (accepted != N_NODES) begin
      fail_run("not every node write was accepted");
    end
    for (int i = 0; i < q_patch.size(); i++) begin
      issue_query(q_patch[i], q_leaf[i]);
      repeat (1 + $urandom % 2) idle_cycle(); // Isolated queries
    end
    wait_drain();
    for (int i = 0; i < q_patch.size(); i++) begin
      issue_query(q_patch[i], q_leaf[i]); // Back to back, one per cycle
    end
    wait_drain();
    for (int i = 0; i < 4; i++) begin
      write_node('0); // Would send every query right if the tree took it
    end
    idle_cycle();
    for (int i = 0; i < q_patch.size(); i++) begin
      issue_query(q_patch[i], q_leaf[i]);
    end
    wait_drain();
    if (due_q.size() != 0) begin
      fail_run("queries still in flight at the end");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: sim/kd_search_vectors.txt
// N split_dim median : one internal node, breadth-first order, decimal
// Q c0 c1 c2 c3 c4 leaf : one query patch and the leaf it must reach, decimal
N 0 64
N 1 64
N 1 128
N 2 64
N 2 128
N 2 192
N 2 256
N 3 64
N 3 128
N 3 192
N 3 256
N 3 320
N 3 384
N 3 448
N 3 512
N 4 64
N 4 128
N 4 192
N 4 256
N 4 320
N 4 384
N 4 448
N 4 512
N 4 576
N 4 640
N 4 704
N 4 768
N 4 832
N 4 896
N 4 960
N 4 1024
Q 63 63 63 63 63 0
Q 63 63 63 63 64 1
Q 63 63 63 64 127 2
Q 63 63 63 64 128 3
Q 63 63 64 127 191 4
Q 63 63 64 127 192 5
Q 63 63 64 128 255 6
Q 63 63 64 128 256 7
Q 63 64 127 191 319 8
Q 63 64 127 191 320 9
Q 63 64 127 192 383 10
Q 63 64 127 192 384 11
Q 63 64 128 255 447 12
Q 63 64 128 255 448 13
Q 63 64 128 256 511 14
Q 63 64 128 256 512 15
Q 64 127 191 319 575 16
Q 64 127 191 319 576 17
Q 64 127 191 320 639 18
Q 64 127 191 320 640 19
Q 64 127 192 383 703 20
Q 64 127 192 383 704 21
Q 64 127 192 384 767 22
Q 64 127 192 384 768 23
Q 64 128 255 447 831 24
Q 64 128 255 447 832 25
Q 64 128 255 448 895 26
Q 64 128 255 448 896 27
Q 64 128 256 511 959 28
Q 64 128 256 511 960 29
Q 64 128 256 512 1023 30
Q 64 128 256 512 1024 31
Q 2047 2047 2047 2047 2047 31
Q 100 128 200 300 400 24
Q 1000 10 500 900 1500 23
Q 1500 2000 30 700 1200 27

// File: all.f
+incdir+source
source/kd_pkg.sv
source/kd_node_loader.sv
source/kd_tree_level.sv
source/kd_leaf_encoder.sv
source/kd_search_top.sv
sim/kd_search_tb.sv

// File: Makefile
SIM := obj_dir/Vkd_search_tb
SRCS := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module kd_search_tb -f all.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
